// ==== src/adc_cfg_pkg.sv ====
package adc_cfg_pkg;

    // one lane of the split ADC bus
    localparam int LANE_W   = 8;
    // rise and fall lanes merged
    localparam int SAMPLE_W = 2 * LANE_W;
    // four samples per FIFO word
    localparam int WORD_W   = 4 * SAMPLE_W;

    typedef logic [LANE_W-1:0]   lane_t;
    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   fifo_word_t;
    // slot of a sample inside its word
    typedef logic [1:0]          phase_t;

endpackage

// ==== src/adc_reg_pkg.sv ====
package adc_reg_pkg;

    localparam int REG_W = 32;

    typedef logic [REG_W-1:0] reg_data_t;

    // host register map, unlisted addresses read as zero
    typedef enum logic [3:0] {
        REG_SHOT_LEN   = 4'd1,
        REG_RUN        = 4'd2,
        REG_STROBE_LEN = 4'd3,
        REG_SOA_LEN    = 4'd4,
        REG_FIFO_STAT  = 4'd5,
        REG_LAST_WORD  = 4'd7,
        REG_ID         = 4'd13
    } reg_addr_e;

    // roughly 60 km of fibre per shot
    localparam reg_data_t SHOT_LEN_RST   = 32'd60000;
    localparam reg_data_t STROBE_LEN_RST = 32'd630;
    localparam reg_data_t SOA_LEN_RST    = 32'd8;

    localparam reg_data_t ID_VALUE = 32'd1000;

endpackage

// ==== src/timing_cfg_if.sv ====
interface timing_cfg_if #(
    parameter int COUNT_W = 32
) ();

    logic               run;
    logic [COUNT_W-1:0] shot_len;
    logic [COUNT_W-1:0] strobe_len;
    logic [COUNT_W-1:0] soa_len;

    // levels held until the next register write
    modport cfg_src (output run, shot_len, strobe_len, soa_len);

    modport cfg_dst (input run, shot_len, strobe_len, soa_len);

endinterface

// ==== src/shot_if.sv ====
interface shot_if #(
    parameter int COUNT_W = 32
) ();
    import adc_cfg_pkg::*;

    logic               run_q;
    logic               wrap;
    logic [COUNT_W-1:0] pos;
    phase_t             phase;

    // timer side
    modport shot_src (output run_q, wrap, pos, phase);

    modport shot_dst (input run_q, wrap, pos, phase);

endinterface

// ==== src/ddr_sample_merge.sv ====
module ddr_sample_merge (
    input  logic                 clk,
    input  adc_cfg_pkg::lane_t   i_adc_rise,
    input  adc_cfg_pkg::lane_t   i_adc_fall,
    output adc_cfg_pkg::sample_t o_sample
);
    import adc_cfg_pkg::*;

    lane_t rise_q;
    lane_t fall_q;
    lane_t sel_rise;
    lane_t sel_fall;

    // stage 1, capture both lanes
    always_ff @(posedge clk)
    begin
        rise_q <= i_adc_rise;
        fall_q <= i_adc_fall;
    end

    // stage 2, lane order is fixed
    // rising edge carries the odd bits
    always_ff @(posedge clk)
    begin
        sel_rise <= rise_q;
        sel_fall <= fall_q;
    end

    // stage 3, bit interleave
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < LANE_W; k++)
        begin
            o_sample[2*k+1] <= sel_rise[k];
            o_sample[2*k]   <= sel_fall[k];
        end
    end

endmodule

// ==== src/ctrl_regs.sv ====
module ctrl_regs #(
    parameter int COUNT_W = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_cfg_wr,
    input  adc_reg_pkg::reg_addr_e  i_cfg_addr,
    input  adc_reg_pkg::reg_data_t  i_cfg_wdata,
    input  adc_reg_pkg::reg_addr_e  i_rd_addr,
    input  adc_reg_pkg::reg_data_t  i_err_count,
    input  adc_cfg_pkg::fifo_word_t i_last_word,
    output adc_reg_pkg::reg_data_t  o_rd_data,
    output logic                    o_fifo_reset,
    timing_cfg_if.cfg_src           cfg
);
    import adc_reg_pkg::*;

    logic               run;
    logic [COUNT_W-1:0] shot_len;
    logic [COUNT_W-1:0] strobe_len;
    logic [COUNT_W-1:0] soa_len;

    // host writes
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            run        <= 1'b0;
            shot_len   <= COUNT_W'(SHOT_LEN_RST);
            strobe_len <= COUNT_W'(STROBE_LEN_RST);
            soa_len    <= COUNT_W'(SOA_LEN_RST);
        end
        else if (i_cfg_wr)
        begin
            case (i_cfg_addr)
                REG_SHOT_LEN:   shot_len   <= COUNT_W'(i_cfg_wdata);
                REG_RUN:        run        <= (i_cfg_wdata != '0);
                REG_STROBE_LEN: strobe_len <= COUNT_W'(i_cfg_wdata);
                REG_SOA_LEN:    soa_len    <= COUNT_W'(i_cfg_wdata);
                default:        ;
            endcase
        end
    end

    // a write to the status register flushes the FIFO
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_fifo_reset <= 1'b0;
        end
        else
        begin
            o_fifo_reset <= i_cfg_wr && (i_cfg_addr == REG_FIFO_STAT);
        end
    end

    // readback, one clock behind the address
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_rd_data <= '0;
        end
        else
        begin
            case (i_rd_addr)
                REG_SHOT_LEN:   o_rd_data <= REG_W'(shot_len);
                REG_RUN:        o_rd_data <= REG_W'(run);
                REG_STROBE_LEN: o_rd_data <= REG_W'(strobe_len);
                REG_SOA_LEN:    o_rd_data <= REG_W'(soa_len);
                REG_FIFO_STAT:  o_rd_data <= i_err_count;
                REG_LAST_WORD:  o_rd_data <= i_last_word[REG_W-1:0];
                REG_ID:         o_rd_data <= ID_VALUE;
                default:        o_rd_data <= '0;
            endcase
        end
    end

    assign cfg.run        = run;
    assign cfg.shot_len   = shot_len;
    assign cfg.strobe_len = strobe_len;
    assign cfg.soa_len    = soa_len;

    // host must not hold the write strobe on the status register
    a_fifo_reset_pulse: assert property (
        @(posedge clk) disable iff (!reset) o_fifo_reset |=> !o_fifo_reset
    ) else $error("fifo reset held for more than one cycle");

endmodule

// ==== src/shot_timer.sv ====
module shot_timer #(
    parameter int COUNT_W = 32
) (
    input  logic          clk,
    input  logic          reset,
    timing_cfg_if.cfg_dst cfg,
    shot_if.shot_src      shot,
    output logic          o_strobe,
    output logic          o_soa
);
    logic               run_q;
    logic               wrap;
    logic [COUNT_W-1:0] pos_q;
    logic [COUNT_W-1:0] strobe_cnt;
    logic [COUNT_W-1:0] soa_cnt;

    // last position of the shot
    assign wrap = run_q && (pos_q == cfg.shot_len);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            run_q      <= 1'b0;
            pos_q      <= '0;
            strobe_cnt <= '0;
            soa_cnt    <= '0;
            o_strobe   <= 1'b0;
            o_soa      <= 1'b0;
        end
        else
        begin
            run_q <= cfg.run;
            if (!run_q)
            begin
                pos_q      <= '0;
                strobe_cnt <= '0;
                soa_cnt    <= '0;
                o_strobe   <= 1'b0;
                o_soa      <= 1'b0;
            end
            else if (wrap)
            begin
                // new shot, fire laser and open the SOA
                pos_q      <= '0;
                strobe_cnt <= '0;
                soa_cnt    <= '0;
                o_strobe   <= 1'b1;
                o_soa      <= 1'b1;
            end
            else
            begin
                pos_q <= pos_q + 1'b1;
                // counters park one past their length
                if (strobe_cnt <= cfg.strobe_len)
                begin
                    strobe_cnt <= strobe_cnt + 1'b1;
                    o_strobe   <= 1'b1;
                end
                else
                begin
                    o_strobe <= 1'b0;
                end
                if (soa_cnt <= cfg.soa_len)
                begin
                    soa_cnt <= soa_cnt + 1'b1;
                    o_soa   <= 1'b1;
                end
                else
                begin
                    o_soa <= 1'b0;
                end
            end
        end
    end

    assign shot.run_q = run_q;
    assign shot.wrap  = wrap;
    assign shot.pos   = pos_q;
    assign shot.phase = pos_q[1:0];

    // shot length is only changed while stopped
    a_pos_in_shot: assert property (
        @(posedge clk) disable iff (!reset) run_q |-> (pos_q <= cfg.shot_len)
    ) else $error("shot position past shot length");

endmodule

// ==== src/sample_packer.sv ====
module sample_packer #(
    parameter int COUNT_W = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  adc_cfg_pkg::sample_t    i_sample,
    input  logic                    i_fifo_full,
    shot_if.shot_dst                shot,
    output logic                    o_fifo_wr,
    output adc_cfg_pkg::fifo_word_t o_fifo_data,
    output adc_reg_pkg::reg_data_t  o_err_count
);
    import adc_cfg_pkg::*;

    localparam phase_t LAST_PHASE = 2'd3;

    logic               word_end;
    logic               ovf_pending;
    logic [COUNT_W-1:0] ovf_pos;

    // the wrap position carries no sample
    assign word_end = shot.run_q && !shot.wrap && (shot.phase == LAST_PHASE);

    // slot order within the word
    always_ff @(posedge clk)
    begin
        if (shot.run_q && !shot.wrap)
        begin
            case (shot.phase)
                2'd0: o_fifo_data[63:48] <= i_sample;
                2'd1: o_fifo_data[15:0]  <= i_sample;
                2'd2: o_fifo_data[31:16] <= i_sample;
                2'd3: o_fifo_data[47:32] <= i_sample;
                default: ;
            endcase
        end
    end

    // write decision at the end of each word
    // after an overflow, wait for the same position in a later shot
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_fifo_wr   <= 1'b0;
            ovf_pending <= 1'b0;
            ovf_pos     <= '0;
            o_err_count <= '0;
        end
        else if (!shot.run_q)
        begin
            o_fifo_wr   <= 1'b0;
            ovf_pending <= 1'b0;
            ovf_pos     <= '0;
        end
        else if (word_end)
        begin
            if (i_fifo_full)
            begin
                o_fifo_wr   <= 1'b0;
                o_err_count <= o_err_count + 1'b1;
                if (!ovf_pending)
                begin
                    ovf_pending <= 1'b1;
                    ovf_pos     <= shot.pos;
                end
            end
            else if (!ovf_pending)
            begin
                o_fifo_wr <= 1'b1;
            end
            else if (shot.pos == ovf_pos)
            begin
                // realigned, resume here
                o_fifo_wr   <= 1'b1;
                ovf_pending <= 1'b0;
                ovf_pos     <= '0;
            end
            else
            begin
                o_fifo_wr <= 1'b0;
            end
        end
        else
        begin
            o_fifo_wr <= 1'b0;
        end
    end

    // position count of the previous clock must end a word
    a_wr_after_last_phase: assert property (
        @(posedge clk) disable iff (!reset)
            o_fifo_wr |-> ($past(shot.pos[1:0]) == LAST_PHASE)
    ) else $error("fifo write not aligned to a word end");

endmodule

// ==== src/adc_emul_top.sv ====
module adc_emul_top #(
    parameter int COUNT_W = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_cfg_wr,
    input  adc_reg_pkg::reg_addr_e  i_cfg_addr,
    input  adc_reg_pkg::reg_data_t  i_cfg_wdata,
    input  adc_reg_pkg::reg_addr_e  i_rd_addr,
    output adc_reg_pkg::reg_data_t  o_rd_data,
    input  adc_cfg_pkg::lane_t      i_adc_rise,
    input  adc_cfg_pkg::lane_t      i_adc_fall,
    input  logic                    i_fifo_full,
    output logic                    o_fifo_wr,
    output adc_cfg_pkg::fifo_word_t o_fifo_data,
    output logic                    o_fifo_reset,
    output logic                    o_strobe,
    output logic                    o_soa
);
    import adc_cfg_pkg::*;
    import adc_reg_pkg::*;

    sample_t   sample;
    reg_data_t err_count;

    timing_cfg_if #(.COUNT_W(COUNT_W)) i_timing_cfg ();
    shot_if #(.COUNT_W(COUNT_W)) i_shot ();

    ddr_sample_merge i_ddr_sample_merge (
        .clk        (clk),
        .i_adc_rise (i_adc_rise),
        .i_adc_fall (i_adc_fall),
        .o_sample   (sample)
    );

    ctrl_regs #(.COUNT_W(COUNT_W)) i_ctrl_regs (
        .clk          (clk),
        .reset        (reset),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .i_rd_addr    (i_rd_addr),
        .i_err_count  (err_count),
        .i_last_word  (o_fifo_data),
        .o_rd_data    (o_rd_data),
        .o_fifo_reset (o_fifo_reset),
        .cfg          (i_timing_cfg.cfg_src)
    );

    shot_timer #(.COUNT_W(COUNT_W)) i_shot_timer (
        .clk      (clk),
        .reset    (reset),
        .cfg      (i_timing_cfg.cfg_dst),
        .shot     (i_shot.shot_src),
        .o_strobe (o_strobe),
        .o_soa    (o_soa)
    );

    sample_packer #(.COUNT_W(COUNT_W)) i_sample_packer (
        .clk         (clk),
        .reset       (reset),
        .i_sample    (sample),
        .i_fifo_full (i_fifo_full),
        .shot        (i_shot.shot_dst),
        .o_fifo_wr   (o_fifo_wr),
        .o_fifo_data (o_fifo_data),
        .o_err_count (err_count)
    );

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

endmodule

// ==== tb/adc_emul_tb.sv ====
module adc_emul_tb;
    import adc_cfg_pkg::*;
    import adc_reg_pkg::*;

    localparam int COUNT_W      = 16;
    localparam int NUM_ROUNDS   = 3;
    localparam int NUM_SHOTS    = 6;
    localparam int MAX_SHOT_LEN = 23;
    // two runs per round, each with a partial first shot, setup writes and a stop
    localparam int CYCLE_LIMIT  = 2 * NUM_ROUNDS * (NUM_SHOTS + 2) * (MAX_SHOT_LEN + 1) + 400;

    logic       clk;
    logic       reset;
    logic       reset_seen = 1'b0;
    int         cycles = 0;
    integer     seed;

    logic       cfg_wr;
    reg_addr_e  cfg_addr;
    reg_data_t  cfg_wdata;
    reg_addr_e  rd_addr;
    reg_data_t  rd_data;
    lane_t      adc_rise;
    lane_t      adc_fall;
    logic       fifo_full;
    logic       fifo_wr;
    fifo_word_t fifo_data;
    logic       fifo_reset;
    logic       strobe;
    logic       soa;

    // reference model state
    logic               full_mode;
    logic               m_run;
    logic               m_run_q;
    logic [COUNT_W-1:0] m_shot_len;
    logic [COUNT_W-1:0] m_strobe_len;
    logic [COUNT_W-1:0] m_soa_len;
    logic [COUNT_W-1:0] m_pos;
    logic [COUNT_W-1:0] m_ovf_pos;
    logic               m_pending;
    reg_data_t          m_err;
    fifo_word_t         m_word = '0;
    lane_t              hist_rise [3];
    lane_t              hist_fall [3];
    logic               m_shot_seen;
    int                 m_k;
    int                 m_wraps = 0;
    int                 strobe_high;
    int                 soa_high;

    // readable registers, last word only read on purpose
    reg_addr_e rd_choices [6] = '{REG_SHOT_LEN, REG_RUN, REG_STROBE_LEN,
                                  REG_SOA_LEN, REG_FIFO_STAT, REG_ID};

    tb_clock #(.PERIOD(100), .RESET_CYCLES(4)) i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    adc_emul_top #(.COUNT_W(COUNT_W)) i_adc_emul_top (
        .clk          (clk),
        .reset        (reset),
        .i_cfg_wr     (cfg_wr),
        .i_cfg_addr   (cfg_addr),
        .i_cfg_wdata  (cfg_wdata),
        .i_rd_addr    (rd_addr),
        .o_rd_data    (rd_data),
        .i_adc_rise   (adc_rise),
        .i_adc_fall   (adc_fall),
        .i_fifo_full  (fifo_full),
        .o_fifo_wr    (fifo_wr),
        .o_fifo_data  (fifo_data),
        .o_fifo_reset (fifo_reset),
        .o_strobe     (strobe),
        .o_soa        (soa)
    );

    // reset as the DUT saw it on the last rising edge
    always @(posedge clk)
    begin
        reset_seen <= reset;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic report_failure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_word(input fifo_word_t got, input fifo_word_t exp, input string what);
        if (got !== exp)
            report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp)
            report_failure($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_count(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
                               input string what);
        if (got !== exp)
            report_failure($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_failure($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    // odd bits from the rising lane, even bits from the falling lane
    function automatic sample_t interleave_lanes(input lane_t rise, input lane_t fall);
        sample_t s;
        for (int k = 0; k < LANE_W; k++)
        begin
            s[2*k+1] = rise[k];
            s[2*k]   = fall[k];
        end
        return s;
    endfunction

    function automatic int pulse_len(input int len, input int shot_len);
        return (len + 2 < shot_len + 1) ? len + 2 : shot_len + 1;
    endfunction

    function automatic reg_data_t readback(input reg_addr_e addr);
        case (addr)
            REG_SHOT_LEN:   return REG_W'(m_shot_len);
            REG_RUN:        return REG_W'(m_run);
            REG_STROBE_LEN: return REG_W'(m_strobe_len);
            REG_SOA_LEN:    return REG_W'(m_soa_len);
            REG_FIFO_STAT:  return m_err;
            REG_LAST_WORD:  return m_word[31:0];
            REG_ID:         return 32'd1000;
            default:        return '0;
        endcase
    endfunction

    task automatic clear_model();
        m_run        = 1'b0;
        m_run_q      = 1'b0;
        m_shot_len   = 16'd60000;
        m_strobe_len = 16'd630;
        m_soa_len    = 16'd8;
        m_pos        = '0;
        m_ovf_pos    = '0;
        m_pending    = 1'b0;
        m_err        = '0;
        m_shot_seen  = 1'b0;
        m_k          = 0;
        strobe_high  = 0;
        soa_high     = 0;
    endtask

    // word packing and the skip and resume rule
    task automatic pack_sample(input logic wrap, input sample_t smp);
        logic exp_wr;
        exp_wr = 1'b0;
        if (m_run_q && !wrap)
        begin
            case (m_pos[1:0])
                2'd0:    m_word[63:48] = smp;
                2'd1:    m_word[15:0]  = smp;
                2'd2:    m_word[31:16] = smp;
                default: m_word[47:32] = smp;
            endcase
        end
        if (!m_run_q)
        begin
            m_pending = 1'b0;
        end
        else if (!wrap && (m_pos[1:0] == 2'd3))
        begin
            if (fifo_full)
            begin
                m_err = m_err + 1;
                if (!m_pending)
                begin
                    m_pending = 1'b1;
                    m_ovf_pos = m_pos;
                end
            end
            else if (!m_pending || (m_pos == m_ovf_pos))
            begin
                exp_wr    = 1'b1;
                m_pending = 1'b0;
            end
        end
        check_flag(fifo_wr, exp_wr, "fifo write strobe");
        if (exp_wr)
            check_word(fifo_data, m_word, "packed fifo word");
    endtask

    // pulses are only defined from the first wrap of a run
    task automatic track_pulses(input logic wrap);
        int strobe_exp;
        int soa_exp;
        strobe_exp = pulse_len(int'(m_strobe_len), int'(m_shot_len));
        soa_exp    = pulse_len(int'(m_soa_len), int'(m_shot_len));
        if (!m_run_q)
        begin
            m_shot_seen = 1'b0;
            check_flag(strobe, 1'b0, "strobe while stopped");
            check_flag(soa, 1'b0, "soa while stopped");
        end
        else
        begin
            if (wrap)
            begin
                if (m_shot_seen)
                begin
                    check_count(COUNT_W'(strobe_high), COUNT_W'(strobe_exp), "strobe high time");
                    check_count(COUNT_W'(soa_high), COUNT_W'(soa_exp), "soa high time");
                end
                m_shot_seen = 1'b1;
                m_k         = 0;
                strobe_high = 0;
                soa_high    = 0;
                m_wraps++;
            end
            else
            begin
                m_k++;
            end
            if (m_shot_seen)
            begin
                // both pulses rise right after the wrap and fall only once
                if (m_k == 0)
                begin
                    check_flag(strobe, 1'b1, "strobe start after wrap");
                    check_flag(soa, 1'b1, "soa start after wrap");
                end
                if (strobe_high < m_k)
                    check_flag(strobe, 1'b0, "strobe after its end");
                if (soa_high < m_k)
                    check_flag(soa, 1'b0, "soa after its end");
                strobe_high += int'(strobe);
                soa_high    += int'(soa);
            end
        end
    endtask

    // one clock, model follows the rising edge that just passed
    task automatic step_cycle();
        logic    wrap;
        sample_t smp;
        @(negedge clk);
        wrap = m_run_q && (m_pos == m_shot_len);
        smp  = interleave_lanes(hist_rise[2], hist_fall[2]);
        if (!reset_seen)
        begin
            clear_model();
            check_reg(rd_data, '0, "readback during reset");
            check_flag(fifo_wr, 1'b0, "fifo write during reset");
            check_flag(fifo_reset, 1'b0, "fifo reset during reset");
            check_flag(strobe, 1'b0, "strobe during reset");
            check_flag(soa, 1'b0, "soa during reset");
        end
        else
        begin
            check_reg(rd_data, readback(rd_addr), "register readback");
            check_flag(fifo_reset, cfg_wr && (cfg_addr == REG_FIFO_STAT), "fifo reset pulse");
            pack_sample(wrap, smp);
            track_pulses(wrap);
            if (!m_run_q || wrap)
                m_pos = '0;
            else
                m_pos = m_pos + 1'b1;
            m_run_q = m_run;
            if (cfg_wr)
            begin
                case (cfg_addr)
                    REG_SHOT_LEN:   m_shot_len   = COUNT_W'(cfg_wdata);
                    REG_RUN:        m_run        = (cfg_wdata != '0);
                    REG_STROBE_LEN: m_strobe_len = COUNT_W'(cfg_wdata);
                    REG_SOA_LEN:    m_soa_len    = COUNT_W'(cfg_wdata);
                    default:        ;
                endcase
            end
        end
        hist_rise[2] = hist_rise[1];
        hist_rise[1] = hist_rise[0];
        hist_rise[0] = adc_rise;
        hist_fall[2] = hist_fall[1];
        hist_fall[1] = hist_fall[0];
        hist_fall[0] = adc_fall;
        // inputs for the next edge
        adc_rise  = lane_t'($random(seed));
        adc_fall  = lane_t'($random(seed));
        fifo_full = full_mode && (($random(seed) & 3) == 0);
        rd_addr   = rd_choices[$unsigned($random(seed)) % 6];
        cfg_wr    = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_e addr, input reg_data_t data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step_cycle();
    endtask

    // hold one register address for a clock
    task automatic read_reg(input reg_addr_e addr);
        rd_addr = addr;
        step_cycle();
    endtask

    // random lengths, then a fixed number of shots and a stop
    task automatic run_shots();
        int target;
        write_reg(REG_SHOT_LEN, 32'd8 + ($unsigned($random(seed)) % 16));
        write_reg(REG_STROBE_LEN, $unsigned($random(seed)) % 12);
        write_reg(REG_SOA_LEN, $unsigned($random(seed)) % 6);
        write_reg(REG_RUN, 32'd1);
        target = m_wraps + NUM_SHOTS;
        while (m_wraps < target)
            step_cycle();
        write_reg(REG_RUN, 32'd0);
        while (m_run_q)
            step_cycle();
        step_cycle();
    endtask

    initial
    begin
        seed      = 32'hd6ed;
        full_mode = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = REG_RUN;
        cfg_wdata = '0;
        rd_addr   = REG_ID;
        adc_rise  = '0;
        adc_fall  = '0;
        fifo_full = 1'b0;

        while (reset_seen !== 1'b1)
            step_cycle();

        // defaults after reset
        read_reg(REG_SHOT_LEN);
        read_reg(REG_RUN);
        read_reg(REG_STROBE_LEN);
        read_reg(REG_SOA_LEN);
        read_reg(REG_FIFO_STAT);
        read_reg(REG_ID);

        for (int r = 0; r < NUM_ROUNDS; r++)
        begin
            full_mode = 1'b0;
            run_shots();
            full_mode = 1'b1;
            run_shots();
        end
        full_mode = 1'b0;
        read_reg(REG_FIFO_STAT);

        // status write, one reset pulse then quiet
        write_reg(REG_FIFO_STAT, 32'd0);
        step_cycle();
        read_reg(REG_LAST_WORD);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== all.f ====
src/adc_cfg_pkg.sv
src/adc_reg_pkg.sv
src/timing_cfg_if.sv
src/shot_if.sv
src/ddr_sample_merge.sv
src/ctrl_regs.sv
src/shot_timer.sv
src/sample_packer.sv
src/adc_emul_top.sv
tb/tb_clock.sv
tb/adc_emul_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = adc_emul_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
